//--- dv/idex_checker.sv
`timescale 1ns/1ns

module idex_checker (
    input logic clk_i,
    input logic reset_i,
    input logic in_valid_i,
    input logic out_valid_i,
    input logic reg_we_i,
    input logic inst_err_i
);

    int fail_count = 0;   // read by the testbench top

    reset_clears_valid: assert property (@(posedge clk_i) reset_i |=> !out_valid_i)
        else begin
            $error("valid_o high in the cycle after a reset cycle");
            fail_count++;
        end

    // one cycle latency, no bubbles added or dropped
    valid_follows_input: assert property (@(posedge clk_i) disable iff (reset_i)
        !$past(reset_i) |-> out_valid_i == $past(in_valid_i))
        else begin
            $error("valid_o does not follow valid_i by one cycle");
            fail_count++;
        end

    error_blocks_write: assert property (@(posedge clk_i) disable iff (reset_i)
        inst_err_i |-> !reg_we_i)
        else begin
            $error("reg_we_o high together with inst_err_o");
            fail_count++;
        end

    idle_outputs_low: assert property (@(posedge clk_i) disable iff (reset_i)
        !out_valid_i |-> !reg_we_i && !inst_err_i)
        else begin
            $error("reg_we_o or inst_err_o high while valid_o is low");
            fail_count++;
        end

endmodule

bind idex_top idex_checker chk0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (valid_i),
    .out_valid_i (valid_o),
    .reg_we_i    (reg_we_o),
    .inst_err_i  (inst_err_o)
);

//--- dv/idex_monitor.sv
`timescale 1ns/1ns
`include "idex_defines.svh"

module idex_monitor (
    input logic                    clk_i,
    input logic                    reset_i,
    input logic                    in_valid_i,
    input logic                    out_valid_i,
    input logic                    reg_we_i,
    input logic [`IDEX_REG_AW-1:0] reg_waddr_i,
    input logic [`IDEX_XLEN-1:0]   reg_wdata_i,
    input logic [`IDEX_XLEN-1:0]   pc_n_i,
    input logic                    inst_err_i
);

    int                      test_q[$];
    logic                    we_q[$];
    logic [`IDEX_REG_AW-1:0] waddr_q[$];
    logic [`IDEX_XLEN-1:0]   wdata_q[$];
    logic [`IDEX_XLEN-1:0]   pc_n_q[$];
    logic                    err_q[$];

    int   outstanding = 0;   // pushed but not yet compared
    int   cur_test    = -1;
    int   cur_errs    = 0;
    int   n_pass      = 0;
    int   n_fail      = 0;
    int   n_stray     = 0;
    logic issued      = 1'b0;   // valid_i at previous sample

    function automatic void push_expect(input int test, input logic we,
                                        input logic [`IDEX_REG_AW-1:0] waddr,
                                        input logic [`IDEX_XLEN-1:0] wdata,
                                        input logic [`IDEX_XLEN-1:0] pc_n,
                                        input logic err);
        test_q.push_back(test);
        we_q.push_back(we);
        waddr_q.push_back(waddr);
        wdata_q.push_back(wdata);
        pc_n_q.push_back(pc_n);
        err_q.push_back(err);
        outstanding++;
    endfunction

    function automatic void close_test();
        if (cur_errs == 0) begin
            $display("test %0d passed", cur_test);
            n_pass++;
        end else begin
            $display("test %0d failed with %0d errors", cur_test, cur_errs);
            n_fail++;
        end
    endfunction

    function automatic void check_field(input string name, input logic [31:0] exp,
                                        input logic [31:0] got);
        if (got !== exp) begin
            $display("error test %0d %s expected %h got %h", cur_test, name, exp, got);
            cur_errs++;
        end
    endfunction

    function automatic void check_result();
        int                      test;
        logic                    we;
        logic [`IDEX_REG_AW-1:0] waddr;
        logic [`IDEX_XLEN-1:0]   wdata;
        logic [`IDEX_XLEN-1:0]   pc_n;
        logic                    err;
        if (test_q.size() == 0) begin
            $display("an instruction was issued with no expected values queued");
            n_stray++;
        end else begin
            test  = test_q.pop_front();
            we    = we_q.pop_front();
            waddr = waddr_q.pop_front();
            wdata = wdata_q.pop_front();
            pc_n  = pc_n_q.pop_front();
            err   = err_q.pop_front();
            outstanding--;
            if (test != cur_test) begin
                if (cur_test >= 0)
                    close_test();
                cur_test = test;
                cur_errs = 0;
            end
            if (out_valid_i !== 1'b1) begin
                $display("valid_o did not appear one cycle after valid_i in test %0d",
                         cur_test);
                cur_errs++;
            end else begin
                check_field("reg_we_o", we, reg_we_i);
                check_field("inst_err_o", err, inst_err_i);
                check_field("pc_n_o", pc_n, pc_n_i);
                if (we) begin   // address and data only matter on a write
                    check_field("reg_waddr_o", waddr, reg_waddr_i);
                    check_field("reg_wdata_o", wdata, reg_wdata_i);
                end
            end
        end
    endfunction

    // sampled mid cycle, away from the driving edge
    always @(negedge clk_i) begin
        if (reset_i) begin
            issued = 1'b0;
        end else begin
            if (issued) begin
                check_result();
            end else if (out_valid_i !== 1'b0) begin
                $display("valid_o was high with no instruction issued one cycle earlier");
                n_stray++;
            end
            issued = in_valid_i;
        end
    end

    function automatic void close_report();
        if (cur_test >= 0)
            close_test();
        cur_test = -1;
        $display("tests passed %0d, tests failed %0d, stray outputs %0d",
                 n_pass, n_fail, n_stray);
    endfunction

    function automatic bit all_ok();
        return n_fail == 0 && n_stray == 0 && outstanding == 0 && n_pass > 0;
    endfunction

endmodule

//--- dv/idex_patterns.txt
# test gap inst pc rs1 rs2 | exp: reg_we reg_waddr reg_wdata pc_n inst_err
# gap is the number of idle cycles before the vector, values in hex except test, gap, we, err
# 1 register-immediate alu
1 0 ff808293 00000100 00000010 00000000 1 05 00000008 00000104 0
1 0 0010a293 00000104 ffffffff 00000000 1 05 00000001 00000108 0
1 0 0010b293 00000108 ffffffff 00000000 1 05 00000000 0000010c 0
1 0 0f00c293 0000010c 12345678 00000000 1 05 12345688 00000110 0
1 0 00f0e293 00000110 12345670 00000000 1 05 1234567f 00000114 0
1 0 ff00f293 00000114 12345678 00000000 1 05 12345670 00000118 0
1 0 00409293 00000118 12345678 00000000 1 05 23456780 0000011c 0
1 0 0040d293 0000011c 80000010 00000000 1 05 08000001 00000120 0
1 0 4040d293 00000120 80000010 00000000 1 05 f8000001 00000124 0
# 2 register-register alu
2 0 002082b3 00000200 00000005 00000007 1 05 0000000c 00000204 0
2 0 402082b3 00000204 00000005 00000007 1 05 fffffffe 00000208 0
2 0 002092b3 00000208 00000001 00000024 1 05 00000010 0000020c 0
2 0 0020a2b3 0000020c fffffffe 00000001 1 05 00000001 00000210 0
2 0 0020b2b3 00000210 fffffffe 00000001 1 05 00000000 00000214 0
2 0 0020c2b3 00000214 ff00ff00 0ff00ff0 1 05 f0f0f0f0 00000218 0
2 0 0020d2b3 00000218 80000000 0000001f 1 05 00000001 0000021c 0
2 0 4020d2b3 0000021c 80000000 0000001f 1 05 ffffffff 00000220 0
2 0 0020e2b3 00000220 ff00ff00 0ff00ff0 1 05 fff0fff0 00000224 0
2 0 0020f2b3 00000224 ff00ff00 0ff00ff0 1 05 0f000f00 00000228 0
# 3 branches, taken then not taken
3 0 00208863 00000300 00000055 00000055 0 00 00000000 00000310 0
3 0 00208863 00000304 00000055 00000056 0 00 00000000 00000308 0
3 0 00209863 00000308 00000001 00000002 0 00 00000000 00000318 0
3 0 00209863 0000030c 00000003 00000003 0 00 00000000 00000310 0
3 0 fe20cce3 00000310 ffffffff 00000001 0 00 00000000 00000308 0
3 0 fe20cce3 00000314 00000001 ffffffff 0 00 00000000 00000318 0
3 0 0020d863 00000318 00000001 ffffffff 0 00 00000000 00000328 0
3 0 0020d863 0000031c ffffffff 00000001 0 00 00000000 00000320 0
3 0 fe20ece3 00000320 00000001 ffffffff 0 00 00000000 00000318 0
3 0 fe20ece3 00000324 ffffffff 00000001 0 00 00000000 00000328 0
3 0 0020f863 00000328 ffffffff 00000001 0 00 00000000 00000338 0
3 0 0020f863 0000032c 00000001 ffffffff 0 00 00000000 00000330 0
# 4 jumps and upper immediates
4 0 100000ef 00000400 00000000 00000000 1 01 00000404 00000500 0
4 0 005100e7 00000404 00001000 00000000 1 01 00000408 00001004 0
4 0 abcde2b7 00000408 00000000 00000000 1 05 abcde000 0000040c 0
4 0 00001297 0000040c 00000000 00000000 1 05 0000140c 00000410 0
# 5 illegal encodings and fence
5 0 0000a283 00000500 00000010 00000000 0 00 00000000 00000000 1
5 0 0020a023 00000504 00000010 00000020 0 00 00000000 00000000 1
5 0 022082b3 00000508 00000003 00000004 0 00 00000000 00000000 1
5 0 300092f3 0000050c 00000001 00000000 0 00 00000000 00000000 1
5 0 422082b3 00000510 00000003 00000004 0 00 00000000 00000000 1
5 0 0000007f 00000514 00000000 00000000 0 00 00000000 00000000 1
5 0 0ff0000f 00000518 00000000 00000000 0 00 00000000 0000051c 0
# 6 back-to-back then gapped issue
6 0 ff808293 00000600 00000100 00000000 1 05 000000f8 00000604 0
6 0 ff808313 00000604 00000200 00000000 1 06 000001f8 00000608 0
6 2 123453b7 00000608 00000000 00000000 1 07 12345000 0000060c 0
6 3 00208863 0000060c 00000000 00000000 0 00 00000000 0000061c 0
6 1 0000007f 00000610 00000000 00000000 0 00 00000000 00000000 1
6 4 002082b3 00000614 00000001 00000002 1 05 00000003 00000618 0

//--- dv/idex_tb.sv
`timescale 1ns/1ns
`include "idex_defines.svh"

module idex_tb;

    localparam string PATTERN_FILE    = "dv/idex_patterns.txt";
    localparam int    WATCHDOG_MARGIN = 20;   // cycles
    localparam int    RESET_CYCLES    = 16;
    localparam int    DRIVE_DELAY     = 1;    // ns after the rising edge

    logic                    clk_i;
    logic                    reset_i;
    logic                    valid_i;
    logic [`IDEX_XLEN-1:0]   inst_i;
    logic [`IDEX_XLEN-1:0]   pc_i;
    logic [`IDEX_XLEN-1:0]   rs1_data_i;
    logic [`IDEX_XLEN-1:0]   rs2_data_i;
    logic                    valid_o;
    logic                    reg_we_o;
    logic [`IDEX_REG_AW-1:0] reg_waddr_o;
    logic [`IDEX_XLEN-1:0]   reg_wdata_o;
    logic [`IDEX_XLEN-1:0]   pc_n_o;
    logic                    inst_err_o;

    string lines[$];   // vector lines without the comment lines
    int    bad_lines;

    idex_top dut0 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .valid_i     (valid_i),
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .valid_o     (valid_o),
        .reg_we_o    (reg_we_o),
        .reg_waddr_o (reg_waddr_o),
        .reg_wdata_o (reg_wdata_o),
        .pc_n_o      (pc_n_o),
        .inst_err_o  (inst_err_o)
    );

    idex_monitor mon0 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .in_valid_i  (valid_i),
        .out_valid_i (valid_o),
        .reg_we_i    (reg_we_o),
        .reg_waddr_i (reg_waddr_o),
        .reg_wdata_i (reg_wdata_o),
        .pc_n_i      (pc_n_o),
        .inst_err_i  (inst_err_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic load_patterns();
        int    fd;
        string line;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("could not open the pattern file %s", PATTERN_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0) begin
                    if (line.len() > 1 && line.getc(0) != "#")
                        lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge clk_i);
        $display("run stopped after %0d cycles, results were still missing", cycles);
        $display("TESTS FAILED");
        $finish;
    endtask

    // entered and left at DRIVE_DELAY after a rising edge
    task automatic apply_vector(input string line);
        int                      test;
        int                      gap;
        int                      we;
        int                      err;
        int                      n;
        logic [`IDEX_XLEN-1:0]   inst;
        logic [`IDEX_XLEN-1:0]   pc;
        logic [`IDEX_XLEN-1:0]   rs1;
        logic [`IDEX_XLEN-1:0]   rs2;
        logic [`IDEX_XLEN-1:0]   wdata;
        logic [`IDEX_XLEN-1:0]   pc_n;
        logic [`IDEX_REG_AW-1:0] waddr;
        n = $sscanf(line, "%d %d %h %h %h %h %d %h %h %h %d", test, gap, inst, pc,
                    rs1, rs2, we, waddr, wdata, pc_n, err);
        if (n != 11) begin
            $display("pattern line could not be read: %s", line);
            bad_lines++;
        end else begin
            if (gap > 0) begin   // idle cycles before this vector
                valid_i = 1'b0;
                repeat (gap) @(posedge clk_i);
                #DRIVE_DELAY;
            end
            valid_i    = 1'b1;
            inst_i     = inst;
            pc_i       = pc;
            rs1_data_i = rs1;
            rs2_data_i = rs2;
            mon0.push_expect(test, we[0], waddr, wdata, pc_n, err[0]);
            @(posedge clk_i);
            #DRIVE_DELAY;
        end
    endtask

    initial begin
        reset_i    = 1'b1;
        valid_i    = 1'b1;   // strobe high through reset with an illegal word
        inst_i     = '0;
        pc_i       = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        bad_lines  = 0;
        load_patterns();
        if (lines.size() == 0) begin
            $display("no vectors were read, nothing was run");
            $display("TESTS FAILED");
        end else begin
            fork
                watchdog(RESET_CYCLES + lines.size() * 2 + WATCHDOG_MARGIN);
            join_none
            repeat (RESET_CYCLES) @(posedge clk_i);
            #DRIVE_DELAY;
            reset_i = 1'b0;
            valid_i = 1'b0;
            @(posedge clk_i);
            #DRIVE_DELAY;
            foreach (lines[k])
                apply_vector(lines[k]);
            valid_i = 1'b0;
            wait (mon0.outstanding == 0);
            repeat (2) @(negedge clk_i);   // catch a late stray valid_o
            mon0.close_report();
            if (bad_lines == 0 && dut0.chk0.fail_count == 0 && mon0.all_ok())
                $display("TESTS PASSED");
            else
                $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/idex_alu.sv
`timescale 1ns/1ns
`include "idex_defines.svh"

module idex_alu
    import idex_pkg::*;
(
    idex_dec_if.alu               dec_i,
    output logic [`IDEX_XLEN-1:0] wdata_o
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = dec_i.alu_b[4:0];
    assign lt_s  = $signed(dec_i.alu_a) < $signed(dec_i.alu_b);
    assign lt_u  = dec_i.alu_a < dec_i.alu_b;

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    wdata_o = dec_i.alu_a + dec_i.alu_b;
            ALU_SUB:    wdata_o = dec_i.alu_a - dec_i.alu_b;
            ALU_SLT:    wdata_o = {{(`IDEX_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   wdata_o = {{(`IDEX_XLEN-1){1'b0}}, lt_u};
            ALU_XOR:    wdata_o = dec_i.alu_a ^ dec_i.alu_b;
            ALU_OR:     wdata_o = dec_i.alu_a | dec_i.alu_b;
            ALU_AND:    wdata_o = dec_i.alu_a & dec_i.alu_b;
            ALU_SLL:    wdata_o = dec_i.alu_a << shamt;
            ALU_SRL:    wdata_o = dec_i.alu_a >> shamt;
            ALU_SRA:    wdata_o = $unsigned($signed(dec_i.alu_a) >>> shamt);   // sign fill
            ALU_PASS_B: wdata_o = dec_i.alu_b;
            default:    wdata_o = '0;
        endcase
    end

endmodule

//--- hdl/idex_branch.sv
`timescale 1ns/1ns
`include "idex_defines.svh"

module idex_branch
    import idex_pkg::*;
(
    idex_dec_if.br                dec_i,
    output logic [`IDEX_XLEN-1:0] pc_next_o
);

    logic                  eq;
    logic                  lt_s;
    logic                  lt_u;
    logic                  taken;
    logic [`IDEX_XLEN-1:0] target;

    assign eq   = (dec_i.br_rs1 == dec_i.br_rs2);
    assign lt_s = $signed(dec_i.br_rs1) < $signed(dec_i.br_rs2);
    assign lt_u = dec_i.br_rs1 < dec_i.br_rs2;

    always_comb begin
        case (dec_i.br_op)
            BR_JUMP: taken = 1'b1;
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = !lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = !lt_u;
            default: taken = 1'b0;   // sequential
        endcase
    end

    // jalr drops bit 0, jal targets are even already
    assign target = (dec_i.tgt_base + dec_i.tgt_off) &
                    ~{{(`IDEX_XLEN-1){1'b0}}, dec_i.br_op == BR_JUMP};

    assign pc_next_o = taken ? target : dec_i.pc + `IDEX_PC_STEP;

endmodule

//--- hdl/idex_commit.sv
`timescale 1ns/1ns
`include "idex_defines.svh"

module idex_commit (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    valid_i,
    idex_dec_if.cm                  cm_i,
    input  logic [`IDEX_XLEN-1:0]   wdata_i,
    input  logic [`IDEX_XLEN-1:0]   pc_next_i,
    output logic                    valid_o,
    output logic                    reg_we_o,
    output logic [`IDEX_REG_AW-1:0] reg_waddr_o,
    output logic [`IDEX_XLEN-1:0]   reg_wdata_o,
    output logic [`IDEX_XLEN-1:0]   pc_n_o,
    output logic                    inst_err_o
);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o    <= 1'b0;
            reg_we_o   <= 1'b0;
            inst_err_o <= 1'b0;
        end else begin
            valid_o    <= valid_i;
            reg_we_o   <= valid_i && cm_i.rd_we && !cm_i.illegal;   // no write on error
            inst_err_o <= valid_i && cm_i.illegal;
        end
    end

    always_ff @(posedge clk_i) begin
        reg_waddr_o <= cm_i.rd;
        reg_wdata_o <= wdata_i;
        pc_n_o      <= cm_i.illegal ? '0 : pc_next_i;   // zero pc flags the trap
    end

endmodule

//--- hdl/idex_dec_if.sv
`timescale 1ns/1ns
`include "idex_defines.svh"

interface idex_dec_if
    import idex_pkg::*;
();

    alu_op_e                 alu_op;
    logic [`IDEX_XLEN-1:0]   alu_a;
    logic [`IDEX_XLEN-1:0]   alu_b;
    br_op_e                  br_op;
    logic [`IDEX_XLEN-1:0]   br_rs1;
    logic [`IDEX_XLEN-1:0]   br_rs2;
    logic [`IDEX_XLEN-1:0]   tgt_base;   // jump or branch target = base + off
    logic [`IDEX_XLEN-1:0]   tgt_off;
    logic [`IDEX_XLEN-1:0]   pc;
    logic [`IDEX_REG_AW-1:0] rd;
    logic                    rd_we;
    logic                    illegal;

    modport dec (output alu_op, alu_a, alu_b, br_op, br_rs1, br_rs2,
                 tgt_base, tgt_off, pc, rd, rd_we, illegal);
    modport alu (input alu_op, alu_a, alu_b);
    modport br  (input br_op, br_rs1, br_rs2, tgt_base, tgt_off, pc);
    modport cm  (input rd, rd_we, illegal);

endinterface

//--- hdl/idex_decode.sv
`timescale 1ns/1ns
`include "idex_defines.svh"

module idex_decode
    import rv_isa_pkg::*;
    import idex_pkg::*;
(
    input  rv_inst_u              inst_i,
    input  logic [`IDEX_XLEN-1:0] pc_i,
    input  logic [`IDEX_XLEN-1:0] rs1_data_i,
    input  logic [`IDEX_XLEN-1:0] rs2_data_i,
    idex_dec_if.dec               dec_o
);

    logic [`IDEX_XLEN-1:0] imm_i;
    logic [`IDEX_XLEN-1:0] imm_b;
    logic [`IDEX_XLEN-1:0] imm_u;
    logic [`IDEX_XLEN-1:0] imm_j;
    logic [`IDEX_XLEN-1:0] shamt;
    logic                  f7_alt;

    assign imm_i = {{(`IDEX_XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
    assign imm_b = {{(`IDEX_XLEN-12){inst_i.b.imm12}}, inst_i.b.imm11,
                    inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
    assign imm_u = {inst_i.u.imm, 12'h000};
    assign imm_j = {{(`IDEX_XLEN-20){inst_i.j.imm20}}, inst_i.j.imm19_12,
                    inst_i.j.imm11, inst_i.j.imm10_1, 1'b0};
    assign shamt = {{(`IDEX_XLEN-5){1'b0}}, inst_i.r.rs2};   // rs2 field as shift amount
    assign f7_alt = (inst_i.r.funct7 == F7_ALT);

    assign dec_o.br_rs1 = rs1_data_i;
    assign dec_o.br_rs2 = rs2_data_i;
    assign dec_o.pc     = pc_i;
    assign dec_o.rd     = inst_i.r.rd;

    always_comb begin
        dec_o.alu_op   = ALU_ADD;
        dec_o.alu_a    = rs1_data_i;
        dec_o.alu_b    = rs2_data_i;
        dec_o.br_op    = BR_SEQ;
        dec_o.tgt_base = pc_i;
        dec_o.tgt_off  = imm_b;
        dec_o.rd_we    = 1'b0;
        dec_o.illegal  = 1'b0;
        case (inst_i.r.opcode)
            OPC_OP_IMM: begin
                dec_o.rd_we = 1'b1;
                dec_o.alu_b = imm_i;
                case (inst_i.r.funct3)
                    F3_ADD_SUB: dec_o.alu_op = ALU_ADD;
                    F3_SLT:     dec_o.alu_op = ALU_SLT;
                    F3_SLTU:    dec_o.alu_op = ALU_SLTU;
                    F3_XOR:     dec_o.alu_op = ALU_XOR;
                    F3_OR:      dec_o.alu_op = ALU_OR;
                    F3_AND:     dec_o.alu_op = ALU_AND;
                    F3_SLL: begin
                        dec_o.alu_op  = ALU_SLL;
                        dec_o.alu_b   = shamt;
                        dec_o.illegal = (inst_i.r.funct7 != F7_BASE);
                    end
                    default: begin   // srli / srai
                        dec_o.alu_op  = f7_alt ? ALU_SRA : ALU_SRL;
                        dec_o.alu_b   = shamt;
                        dec_o.illegal = (inst_i.r.funct7 != F7_BASE) && !f7_alt;
                    end
                endcase
            end
            OPC_OP: begin
                dec_o.rd_we   = 1'b1;
                // only sub and sra accept the alternate funct7
                dec_o.illegal = ((inst_i.r.funct7 != F7_BASE) && !f7_alt) ||
                                (f7_alt && (inst_i.r.funct3 != F3_ADD_SUB) &&
                                 (inst_i.r.funct3 != F3_SR));
                case (inst_i.r.funct3)
                    F3_ADD_SUB: dec_o.alu_op = f7_alt ? ALU_SUB : ALU_ADD;
                    F3_SLL:     dec_o.alu_op = ALU_SLL;
                    F3_SLT:     dec_o.alu_op = ALU_SLT;
                    F3_SLTU:    dec_o.alu_op = ALU_SLTU;
                    F3_XOR:     dec_o.alu_op = ALU_XOR;
                    F3_SR:      dec_o.alu_op = f7_alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      dec_o.alu_op = ALU_OR;
                    default:    dec_o.alu_op = ALU_AND;
                endcase
            end
            OPC_BRANCH: begin
                case (inst_i.r.funct3)
                    F3_BEQ:  dec_o.br_op = BR_BEQ;
                    F3_BNE:  dec_o.br_op = BR_BNE;
                    F3_BLT:  dec_o.br_op = BR_BLT;
                    F3_BGE:  dec_o.br_op = BR_BGE;
                    F3_BLTU: dec_o.br_op = BR_BLTU;
                    F3_BGEU: dec_o.br_op = BR_BGEU;
                    default: dec_o.illegal = 1'b1;
                endcase
            end
            OPC_JAL: begin
                dec_o.rd_we   = 1'b1;
                dec_o.alu_a   = pc_i;            // link value pc + step
                dec_o.alu_b   = `IDEX_PC_STEP;
                dec_o.br_op   = BR_JUMP;
                dec_o.tgt_off = imm_j;
            end
            OPC_JALR: begin
                dec_o.rd_we    = 1'b1;
                dec_o.alu_a    = pc_i;
                dec_o.alu_b    = `IDEX_PC_STEP;
                dec_o.br_op    = BR_JUMP;
                dec_o.tgt_base = rs1_data_i;
                dec_o.tgt_off  = imm_i;
                dec_o.illegal  = (inst_i.r.funct3 != F3_JALR);
            end
            OPC_LUI: begin
                dec_o.rd_we  = 1'b1;
                dec_o.alu_op = ALU_PASS_B;
                dec_o.alu_b  = imm_u;
            end
            OPC_AUIPC: begin
                dec_o.rd_we = 1'b1;
                dec_o.alu_a = pc_i;
                dec_o.alu_b = imm_u;
            end
            OPC_FENCE: dec_o.illegal = (inst_i.r.funct3 != F3_FENCE);   // no-op
            default:   dec_o.illegal = 1'b1;   // loads, stores, system, unknown
        endcase
    end

endmodule

//--- hdl/idex_defines.svh
`ifndef IDEX_DEFINES_SVH
`define IDEX_DEFINES_SVH

// data path and pc width
`define IDEX_XLEN 32

// register file address width
`define IDEX_REG_AW 5

`define IDEX_PC_STEP 4   // sequential pc increment

`endif

//--- hdl/idex_pkg.sv
package idex_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B    // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_SEQ,       // fall through to pc + step
        BR_JUMP,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } br_op_e;

endpackage

//--- hdl/idex_top.sv
`timescale 1ns/1ns
`include "idex_defines.svh"

module idex_top (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    valid_i,
    input  logic [`IDEX_XLEN-1:0]   inst_i,
    input  logic [`IDEX_XLEN-1:0]   pc_i,
    input  logic [`IDEX_XLEN-1:0]   rs1_data_i,
    input  logic [`IDEX_XLEN-1:0]   rs2_data_i,
    output logic                    valid_o,
    output logic                    reg_we_o,
    output logic [`IDEX_REG_AW-1:0] reg_waddr_o,
    output logic [`IDEX_XLEN-1:0]   reg_wdata_o,
    output logic [`IDEX_XLEN-1:0]   pc_n_o,
    output logic                    inst_err_o
);

    logic [`IDEX_XLEN-1:0] wdata;     // alu result
    logic [`IDEX_XLEN-1:0] pc_next;   // branch unit result

    idex_dec_if dec_if ();

    idex_decode u_decode (
        .inst_i     (inst_i),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .dec_o      (dec_if.dec)
    );

    idex_alu u_alu (
        .dec_i   (dec_if.alu),
        .wdata_o (wdata)
    );

    idex_branch u_branch (
        .dec_i     (dec_if.br),
        .pc_next_o (pc_next)
    );

    idex_commit u_commit (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .valid_i     (valid_i),
        .cm_i        (dec_if.cm),
        .wdata_i     (wdata),
        .pc_next_i   (pc_next),
        .valid_o     (valid_o),
        .reg_we_o    (reg_we_o),
        .reg_waddr_o (reg_waddr_o),
        .reg_wdata_o (reg_wdata_o),
        .pc_n_o      (pc_n_o),
        .inst_err_o  (inst_err_o)
    );

endmodule

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;    // shamt for immediate shifts
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_t;

    // store format, decoded only to the illegal path
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } rv_s_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } rv_b_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_t;

    typedef union packed {
        rv_r_t r;
        rv_i_t i;
        rv_s_t s;
        rv_b_t b;
        rv_u_t u;
        rv_j_t j;
    } rv_inst_u;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;

    // op and op-imm
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_JALR  = 3'b000;
    localparam logic [2:0] F3_FENCE = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // sub and sra

endpackage

//--- idex.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/idex_pkg.sv
hdl/idex_dec_if.sv
hdl/idex_decode.sv
hdl/idex_alu.sv
hdl/idex_branch.sv
hdl/idex_commit.sv
hdl/idex_top.sv
dv/idex_checker.sv
dv/idex_monitor.sv
dv/idex_tb.sv
